// File: rtl/sched_pkg.sv
package sched_pkg;

	// ********************
	// Basic words
	// ********************

	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;

	// Byte select bits below the word index.
	localparam int SUBWORD_BITS = 2;

	localparam int BYTE_BITS = 8;

	// ********************
	// Core bus
	// ********************

	typedef struct packed {
		logic  valid;
		logic  write;
		word_t addr;
		word_t wdata;
		strb_t wstrb;
	} mem_req_t;

	typedef struct packed {
		logic  ready;
		logic  err;
		word_t rdata;
	} mem_resp_t;

	// ********************
	// AXI-lite bus
	// ********************

	typedef logic [1:0] axi_resp_t;

	// Anything other than OKAY counts as an error.
	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		logic  awvalid;
		word_t awaddr;
		logic  wvalid;
		word_t wdata;
		strb_t wstrb;
		logic  bready;
		logic  arvalid;
		word_t araddr;
		logic  rready;
	} axil_req_t;

	typedef struct packed {
		logic      awready;
		logic      wready;
		logic      bvalid;
		axi_resp_t bresp;
		logic      arready;
		logic      rvalid;
		word_t     rdata;
		axi_resp_t rresp;
	} axil_rsp_t;

endpackage

// File: rtl/sched_scratchpad.sv
module sched_scratchpad #(
	parameter int SCRATCH_WORDS = 256
) (
	input  logic                             clk,
	input  logic                             en,
	input  logic                             we,
	input  logic [$clog2(SCRATCH_WORDS)-1:0] index,
	input  sched_pkg::word_t                 wdata,
	input  sched_pkg::strb_t                 wstrb,
	output sched_pkg::word_t                 rdata
);

	localparam int BYTES = $bits(sched_pkg::strb_t);
	localparam int BYTE_BITS = sched_pkg::BYTE_BITS;

	sched_pkg::word_t mem [SCRATCH_WORDS];

	// ********************
	// Byte-strobed write
	// ********************

	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int i = 0; i < BYTES; i++) begin
				if (wstrb[i]) begin
					mem[index][i*BYTE_BITS +: BYTE_BITS] <= wdata[i*BYTE_BITS +: BYTE_BITS];
				end
			end
		end
	end

	// ********************
	// Registered read
	// ********************

	// Old contents are returned when read and write hit the same word.
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[index];
		end
	end

endmodule

// File: rtl/axil_master_fsm.sv
module axil_master_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  sched_pkg::mem_req_t  req,
	input  logic                 expired,
	output logic                 run,
	output logic                 done,
	output logic                 err,
	output sched_pkg::word_t     rdata,
	output sched_pkg::axil_req_t axil,
	input  sched_pkg::axil_rsp_t axil_rsp
);

	typedef enum logic [2:0] {
		s_idle,
		s_write,
		s_bresp,
		s_raddr,
		s_rdata,
		s_finish
	} state_t;

	state_t state;

	// Set once the address or data beat has been taken.
	logic aw_ok;
	logic w_ok;

	logic aw_fire;
	logic w_fire;
	logic write_accepted;

	sched_pkg::mem_req_t req_q;

	assign aw_fire = axil.awvalid & axil_rsp.awready;
	assign w_fire = axil.wvalid & axil_rsp.wready;
	assign write_accepted = (aw_ok | aw_fire) & (w_ok | w_fire);

	assign run = (state != s_idle) && (state != s_finish);
	assign done = state == s_finish;

	// ********************
	// Request and read data
	// ********************

	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= req;
			rdata <= '0;
		end else if (state == s_rdata && axil_rsp.rvalid && !expired) begin
			rdata <= axil_rsp.rdata;
		end
	end

	// ********************
	// State machine
	// ********************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			aw_ok <= 1'b0;
			w_ok <= 1'b0;
			err <= 1'b0;
		end else if (run && expired) begin
			// Slave never answered.
			state <= s_finish;
			err <= 1'b1;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						state <= req.write ? s_write : s_raddr;
						aw_ok <= 1'b0;
						w_ok <= 1'b0;
						err <= 1'b0;
					end
				end
				s_write: begin
					if (write_accepted) begin
						state <= s_bresp;
					end else begin
						aw_ok <= aw_ok | aw_fire;
						w_ok <= w_ok | w_fire;
					end
				end
				s_bresp: begin
					if (axil_rsp.bvalid) begin
						state <= s_finish;
						err <= axil_rsp.bresp != sched_pkg::AXI_RESP_OKAY;
					end
				end
				s_raddr: begin
					if (axil_rsp.arready) begin
						state <= s_rdata;
					end
				end
				s_rdata: begin
					if (axil_rsp.rvalid) begin
						state <= s_finish;
						err <= axil_rsp.rresp != sched_pkg::AXI_RESP_OKAY;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// ********************
	// Bus outputs
	// ********************

	always_comb begin
		axil.awvalid = (state == s_write) && !aw_ok;
		axil.awaddr = req_q.addr;
		axil.wvalid = (state == s_write) && !w_ok;
		axil.wdata = req_q.wdata;
		axil.wstrb = req_q.wstrb;
		axil.bready = state == s_bresp;
		axil.arvalid = state == s_raddr;
		axil.araddr = req_q.addr;
		axil.rready = state == s_rdata;
	end

endmodule

// File: rtl/bus_timeout_timer.sv
module bus_timeout_timer #(
	parameter int AXI_TIMEOUT = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic expired
);

	localparam int COUNT_BITS = $clog2(AXI_TIMEOUT + 1);

	logic [COUNT_BITS-1:0] count;

	// Stops at the limit, so expired stays up until run drops.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;
		end else if (!expired) begin
			count <= count + 1'b1;
		end
	end

	assign expired = count == COUNT_BITS'(AXI_TIMEOUT);

endmodule

// File: rtl/sched_mem_router.sv
module sched_mem_router #(
	parameter int SCRATCH_WORDS = 256
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  sched_pkg::mem_req_t              req,
	output sched_pkg::mem_resp_t             resp,

	output logic                             sp_en,
	output logic                             sp_we,
	output logic [$clog2(SCRATCH_WORDS)-1:0] sp_index,
	input  sched_pkg::word_t                 sp_rdata,

	output logic                             axi_start,
	input  logic                             axi_done,
	input  logic                             axi_err,
	input  sched_pkg::word_t                 axi_rdata
);

	localparam int INDEX_BITS = $clog2(SCRATCH_WORDS);
	localparam int LOW_BITS = INDEX_BITS + sched_pkg::SUBWORD_BITS;
	localparam int ADDR_BITS = $bits(sched_pkg::word_t);

	logic sp_hit;
	logic sp_sel;
	logic axi_sel;

	// Scratchpad access in flight, then its answer cycle.
	logic sp_wait;
	logic sp_ack;

	logic axi_busy;

	assign sp_hit = ~|req.addr[ADDR_BITS-1:LOW_BITS];
	assign sp_sel = req.valid & sp_hit;
	assign axi_sel = req.valid & ~sp_hit;

	assign sp_index = req.addr[LOW_BITS-1:sched_pkg::SUBWORD_BITS];
	assign sp_en = sp_sel & ~sp_wait & ~sp_ack;
	assign sp_we = req.write;

	assign axi_start = axi_sel & ~axi_busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sp_wait <= 1'b0;
			sp_ack <= 1'b0;
			axi_busy <= 1'b0;
		end else begin
			sp_wait <= sp_en;
			sp_ack <= sp_wait;
			if (axi_start) begin
				axi_busy <= 1'b1;
			end else if (axi_done) begin
				axi_busy <= 1'b0;
			end
		end
	end

	// ********************
	// Response mux
	// ********************

	always_comb begin
		resp.ready = sp_ack | axi_done;
		resp.err = axi_done & axi_err;
		if (sp_ack) begin
			resp.rdata = req.write ? '0 : sp_rdata;
		end else begin
			resp.rdata = axi_rdata;
		end
	end

endmodule

// File: rtl/sched_mem_top.sv
module sched_mem_top #(
	parameter int SCRATCH_WORDS = 256,
	parameter int AXI_TIMEOUT = 64
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sched_pkg::mem_req_t  req,
	output sched_pkg::mem_resp_t resp,
	output sched_pkg::axil_req_t axil,
	input  sched_pkg::axil_rsp_t axil_rsp
);

	logic                             sp_en;
	logic                             sp_we;
	logic [$clog2(SCRATCH_WORDS)-1:0] sp_index;
	sched_pkg::word_t                 sp_rdata;

	logic             axi_start;
	logic             axi_done;
	logic             axi_err;
	sched_pkg::word_t axi_rdata;

	logic run;
	logic expired;

	sched_mem_router #(
		.SCRATCH_WORDS(SCRATCH_WORDS)
	) router (
		.clk,
		.rst_n,
		.req,
		.resp,
		.sp_en,
		.sp_we,
		.sp_index,
		.sp_rdata,
		.axi_start,
		.axi_done,
		.axi_err,
		.axi_rdata
	);

	sched_scratchpad #(
		.SCRATCH_WORDS(SCRATCH_WORDS)
	) scratchpad (
		.clk,
		.en(sp_en),
		.we(sp_we),
		.index(sp_index),
		.wdata(req.wdata),
		.wstrb(req.wstrb),
		.rdata(sp_rdata)
	);

	axil_master_fsm axi_master (
		.clk,
		.rst_n,
		.start(axi_start),
		.req,
		.expired,
		.run,
		.done(axi_done),
		.err(axi_err),
		.rdata(axi_rdata),
		.axil,
		.axil_rsp
	);

	bus_timeout_timer #(
		.AXI_TIMEOUT(AXI_TIMEOUT)
	) timer (
		.clk,
		.rst_n,
		.run,
		.expired
	);

endmodule

// File: tests/sched_mem_model.svh
`ifndef SCHED_MEM_MODEL_SVH
`define SCHED_MEM_MODEL_SVH

// Address regions, by the top address nibble.
localparam logic [3:0] REGION_SCRATCH = 4'h0;
localparam logic [3:0] REGION_OK = 4'h1;
localparam logic [3:0] REGION_ERR = 4'h2;
localparam logic [3:0] REGION_DEAD = 4'h3;

localparam int SP_INDEX_BITS = $clog2(SCRATCH_WORDS);

sched_pkg::word_t sp_model [SCRATCH_WORDS];
sched_pkg::word_t slave_model [SCRATCH_WORDS];

// Odd multiplier, so every index gets its own word.
function automatic sched_pkg::word_t fill_word(int i);
	return 32'h9e37_79b9 * (i + 1);
endfunction

function automatic sched_pkg::word_t merge_strb(sched_pkg::word_t old,
		sched_pkg::word_t data, sched_pkg::strb_t strb);
	sched_pkg::word_t w;
	w = old;
	for (int b = 0; b < $bits(sched_pkg::strb_t); b++) begin
		if (strb[b]) begin
			w[b*sched_pkg::BYTE_BITS +: sched_pkg::BYTE_BITS] =
				data[b*sched_pkg::BYTE_BITS +: sched_pkg::BYTE_BITS];
		end
	end
	return w;
endfunction

function automatic logic in_scratch(sched_pkg::word_t addr);
	return (addr >> (SP_INDEX_BITS + sched_pkg::SUBWORD_BITS)) == 0;
endfunction

function automatic logic bus_active(sched_pkg::axil_req_t a);
	return a.awvalid | a.wvalid | a.bready | a.arvalid | a.rready;
endfunction

// Address, data and strobes as the master must show them.
function automatic sched_pkg::axil_req_t expected_bus(sched_pkg::mem_req_t r);
	sched_pkg::axil_req_t a;
	a = '0;
	a.awaddr = r.addr;
	a.araddr = r.addr;
	a.wdata = r.wdata;
	a.wstrb = r.wstrb;
	return a;
endfunction

// Expected answer to one request. The model memories take the write.
function automatic sched_pkg::mem_resp_t apply_request(sched_pkg::mem_req_t r);
	sched_pkg::mem_resp_t want;
	int idx;
	want = '0;
	want.ready = 1'b1;
	idx = r.addr[sched_pkg::SUBWORD_BITS +: SP_INDEX_BITS];
	if (in_scratch(r.addr)) begin
		if (r.write) begin
			sp_model[idx] = merge_strb(sp_model[idx], r.wdata, r.wstrb);
		end else begin
			want.rdata = sp_model[idx];
		end
	end else if (r.addr[31:28] != REGION_OK) begin
		want.err = 1'b1;
	end else if (r.write) begin
		slave_model[idx] = merge_strb(slave_model[idx], r.wdata, r.wstrb);
	end else begin
		want.rdata = slave_model[idx];
	end
	return want;
endfunction

`endif

// File: tests/tb_sched_mem.sv
module tb_sched_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SCRATCH_WORDS = 256;
	localparam int AXI_TIMEOUT = 64;
	localparam int RESP_LIMIT = AXI_TIMEOUT + 16;
	localparam int IDLE_LIMIT = 5000;
	localparam sched_pkg::axi_resp_t AXI_SLVERR = 2'b10;

	logic clk;
	logic rst_n;
	sched_pkg::mem_req_t req;
	sched_pkg::mem_resp_t resp;
	sched_pkg::axil_req_t axil;
	sched_pkg::axil_rsp_t axil_rsp;

	// Request in flight, seen by the slave responder.
	sched_pkg::mem_req_t cur_req;
	sched_pkg::word_t slave_mem [SCRATCH_WORDS];

	`include "sched_mem_model.svh"

	sched_mem_top #(
		.SCRATCH_WORDS(SCRATCH_WORDS),
		.AXI_TIMEOUT(AXI_TIMEOUT)
	) sched_mem_top_i (
		.clk,
		.rst_n,
		.req,
		.resp,
		.axil,
		.axil_rsp
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ********************
	// Reporting and checks
	// ********************

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(string what);
		$display("FAIL at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic report_timeout(string what);
		$display("Timeout at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic check_resp(sched_pkg::mem_resp_t got, sched_pkg::mem_resp_t want,
			string what);
		if (got !== want) begin
			report_mismatch($sformatf("%s: got ready %b err %b rdata %h, expected %b %b %h",
				what, got.ready, got.err, got.rdata, want.ready, want.err, want.rdata));
		end
	endtask

	task automatic check_axil(sched_pkg::axil_req_t got, sched_pkg::axil_req_t want,
			string what);
		if (got.awaddr !== want.awaddr || got.araddr !== want.araddr ||
				got.wdata !== want.wdata || got.wstrb !== want.wstrb) begin
			report_mismatch($sformatf("%s: got addr %h/%h data %h strb %h, expected %h %h %h",
				what, got.awaddr, got.araddr, got.wdata, got.wstrb,
				want.awaddr, want.wdata, want.wstrb));
		end
	endtask

	task automatic check_quiet(int n);
		repeat (n) begin
			@(negedge clk);
			if (resp.ready !== 1'b0 || bus_active(axil) !== 1'b0) begin
				report_mismatch("ready or an AXI valid is high before the first request");
			end
		end
	endtask

	// ********************
	// Core side
	// ********************

	function automatic sched_pkg::mem_req_t random_request(logic [3:0] region);
		sched_pkg::mem_req_t r;
		r.valid = 1'b1;
		r.write = 1'($urandom_range(1));
		r.addr = {region, 28'($urandom_range(SCRATCH_WORDS - 1)) << sched_pkg::SUBWORD_BITS};
		r.wdata = $urandom();
		r.wstrb = 4'($urandom_range(15));
		return r;
	endfunction

	function automatic logic [3:0] pick_region();
		int roll;
		roll = $urandom_range(99);
		return roll < 45 ? REGION_SCRATCH :
			roll < 85 ? REGION_OK :
			roll < 97 ? REGION_ERR : REGION_DEAD;
	endfunction

	task automatic do_request(sched_pkg::mem_req_t r);
		sched_pkg::mem_resp_t want;
		int cycles;
		want = apply_request(r);
		cur_req = r;
		req = r;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > RESP_LIMIT) begin
				report_timeout("the DUT never answered a core request");
			end
		end while (resp.ready !== 1'b1);
		check_resp(resp, want, $sformatf("%s at %h", r.write ? "write" : "read", r.addr));
		if (in_scratch(r.addr) && cycles != 2) begin
			report_mismatch($sformatf("scratchpad answered after %0d cycles", cycles));
		end
		@(negedge clk);
		req = '0;
	endtask

	// ********************
	// AXI-lite slave
	// ********************

	task automatic wait_bus_request();
		int cycles;
		cycles = 0;
		while (axil.awvalid !== 1'b1 && axil.arvalid !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > IDLE_LIMIT) begin
				report_timeout("the AXI slave saw no request");
			end
		end
	endtask

	task automatic wait_bus_idle();
		int cycles;
		cycles = 0;
		while (bus_active(axil) !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > AXI_TIMEOUT + 8) begin
				report_timeout("an AXI valid or ready stayed high past the timeout");
			end
		end
	endtask

	// Response valid stays up until the master takes it.
	task automatic wait_resp_accept(logic is_write);
		int cycles;
		cycles = 0;
		while ((is_write ? axil.bready : axil.rready) !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > AXI_TIMEOUT + 8) begin
				report_timeout(is_write ? "the master never raised bready" :
					"the master never raised rready");
			end
		end
		@(negedge clk);
	endtask

	task automatic serve_write(logic slave_err);
		int aw_delay;
		int w_delay;
		int idx;
		aw_delay = $urandom_range(5);
		w_delay = $urandom_range(5);
		idx = axil.awaddr[sched_pkg::SUBWORD_BITS +: SP_INDEX_BITS];
		for (int n = 0; n <= aw_delay || n <= w_delay; n++) begin
			axil_rsp.awready = n == aw_delay;
			axil_rsp.wready = n == w_delay;
			@(negedge clk);
		end
		axil_rsp.awready = 1'b0;
		axil_rsp.wready = 1'b0;
		if (!slave_err) begin
			slave_mem[idx] = merge_strb(slave_mem[idx], axil.wdata, axil.wstrb);
		end
		repeat ($urandom_range(5)) @(negedge clk);
		axil_rsp.bvalid = 1'b1;
		axil_rsp.bresp = slave_err ? AXI_SLVERR : sched_pkg::AXI_RESP_OKAY;
		wait_resp_accept(1'b1);
		axil_rsp.bvalid = 1'b0;
	endtask

	task automatic serve_read(logic slave_err);
		int idx;
		idx = axil.araddr[sched_pkg::SUBWORD_BITS +: SP_INDEX_BITS];
		repeat ($urandom_range(5)) @(negedge clk);
		axil_rsp.arready = 1'b1;
		@(negedge clk);
		axil_rsp.arready = 1'b0;
		repeat ($urandom_range(5)) @(negedge clk);
		axil_rsp.rvalid = 1'b1;
		axil_rsp.rresp = slave_err ? AXI_SLVERR : sched_pkg::AXI_RESP_OKAY;
		axil_rsp.rdata = slave_err ? '0 : slave_mem[idx];
		wait_resp_accept(1'b0);
		axil_rsp.rvalid = 1'b0;
	endtask

	initial begin : slave_responder
		logic [3:0] region;
		axil_rsp = '0;
		forever begin
			wait_bus_request();
			region = axil.awvalid ? axil.awaddr[31:28] : axil.araddr[31:28];
			check_axil(axil, expected_bus(cur_req), "AXI request fields");
			// A dead address gets no ready and no response at all.
			if (region == REGION_DEAD) begin
				wait_bus_idle();
			end else if (axil.awvalid) begin
				serve_write(region == REGION_ERR);
			end else begin
				serve_read(region == REGION_ERR);
			end
		end
	end

	// ********************
	// Stimulus
	// ********************

	initial begin
		sched_pkg::mem_req_t r;
		void'($urandom(64));
		for (int i = 0; i < SCRATCH_WORDS; i++) begin
			slave_mem[i] = fill_word(i);
			slave_model[i] = fill_word(i);
		end
		req = '0;
		cur_req = '0;
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check_quiet(8);

		// Full-word fill so no scratchpad word is undefined.
		for (int i = 0; i < SCRATCH_WORDS; i++) begin
			r = random_request(REGION_SCRATCH);
			r.write = 1'b1;
			r.wstrb = 4'hf;
			r.addr = sched_pkg::word_t'(i) << sched_pkg::SUBWORD_BITS;
			do_request(r);
		end
		repeat (96) do_request(random_request(REGION_SCRATCH));
		repeat (48) do_request(random_request(REGION_OK));
		repeat (12) do_request(random_request(REGION_ERR));
		repeat (4) begin
			do_request(random_request(REGION_DEAD));
			do_request(random_request(REGION_OK));
		end
		repeat (500) do_request(random_request(pick_region()));

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: tb.f
+incdir+tests
rtl/sched_pkg.sv
rtl/sched_scratchpad.sv
rtl/axil_master_fsm.sv
rtl/bus_timeout_timer.sv
rtl/sched_mem_router.sv
rtl/sched_mem_top.sv
tests/tb_sched_mem.sv
